// ==== rtl/noc_defines.svh ====
// widths, queue depth, port count and header field sizes of the router tile
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// one flit word on every port.
`define NOC_FLIT_W 16

// entries in each input queue, and the pointer width that addresses them.
`define NOC_FIFO_DEPTH 4
`define NOC_FIFO_AW 2

// local, north, south, east and west.
`define NOC_PORTS 5
`define NOC_PORT_IDX_W 3

// header view from the top: tag, destination row, destination column, payload.
// the tag sits in bits 15..12, row in 11..10, column in 9..8, payload in 7..0.
`define NOC_TAG_W 4
`define NOC_COORD_W 2
`define NOC_PAYLOAD_W 8

`endif

// ==== rtl/noc_pkg.sv ====
// flit union, port index type and port enumeration of the router tile
`include "noc_defines.svh"

package noc_pkg;

  // the field order fixes the bit positions, tag at the top.
  typedef struct packed {
    logic [`NOC_TAG_W-1:0]     tag;
    logic [`NOC_COORD_W-1:0]   dst_row;
    logic [`NOC_COORD_W-1:0]   dst_col;
    logic [`NOC_PAYLOAD_W-1:0] payload;
  } flit_hdr_t;

  // queues move the raw word, the route logic reads the header view.
  typedef union packed {
    logic [`NOC_FLIT_W-1:0] raw;
    flit_hdr_t              hdr;
  } flit_u;

  typedef logic [`NOC_PORT_IDX_W-1:0] port_idx_t;

  typedef enum logic [`NOC_PORT_IDX_W-1:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_SOUTH = 3'd2,
    PORT_EAST  = 3'd3,
    PORT_WEST  = 3'd4
  } port_e;

endpackage

// ==== rtl/flit_fifo.sv ====
// four-entry circular flit queue with full and empty flags
`timescale 1ns/1ns
`include "noc_defines.svh"

module flit_fifo
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           wr_en,
  input  noc_pkg::flit_u wr_flit,
  input  logic           rd_en,
  output noc_pkg::flit_u rd_flit,
  output logic           full,
  output logic           empty
);
  import noc_pkg::*;

  localparam int CNT_W = $clog2(`NOC_FIFO_DEPTH + 1);

  flit_u                  mem [`NOC_FIFO_DEPTH];
  logic [`NOC_FIFO_AW-1:0] wr_ptr;
  logic [`NOC_FIFO_AW-1:0] rd_ptr;
  logic [CNT_W-1:0]        count;

  assign full    = (count == CNT_W'(`NOC_FIFO_DEPTH));
  assign empty   = (count == '0);
  assign rd_flit = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_flit;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == `NOC_FIFO_AW'(`NOC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == `NOC_FIFO_AW'(`NOC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // a write and a pop in the same cycle leave the count alone.
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the writer must see full and the reader must see empty.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_en |-> !full
  ) else $error("flit_fifo written while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_en |-> !empty
  ) else $error("flit_fifo popped while empty");

endmodule

// ==== rtl/input_port.sv ====
// input queue and row-first route computation for one router port
`timescale 1ns/1ns
`include "noc_defines.svh"

module input_port
#(
  parameter int unsigned ROUTER_ROW = 0,
  parameter int unsigned ROUTER_COL = 0
)
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  noc_pkg::flit_u     in_flit,
  output logic               in_ready,
  input  logic               grant,
  output logic               req_valid,
  output noc_pkg::port_idx_t req_port,
  output noc_pkg::flit_u     head_flit
);
  import noc_pkg::*;

  localparam logic [`NOC_COORD_W-1:0] MY_ROW = `NOC_COORD_W'(ROUTER_ROW);
  localparam logic [`NOC_COORD_W-1:0] MY_COL = `NOC_COORD_W'(ROUTER_COL);

  logic  full;
  logic  empty;
  flit_u head;
  port_e route;

  flit_fifo u_fifo
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (in_valid && in_ready),
    .wr_flit (in_flit),
    .rd_en   (grant),
    .rd_flit (head),
    .full    (full),
    .empty   (empty)
  );

  assign in_ready  = !full;
  assign req_valid = !empty;
  assign head_flit = head;
  assign req_port  = port_idx_t'(route);

  // dimension order: settle the row first, then the column.
  // the arrival port plays no part, so a flit may turn back.
  always_comb
  begin
    if (head.hdr.dst_row < MY_ROW)
      route = PORT_NORTH;
    else if (head.hdr.dst_row > MY_ROW)
      route = PORT_SOUTH;
    else if (head.hdr.dst_col < MY_COL)
      route = PORT_WEST;
    else if (head.hdr.dst_col > MY_COL)
      route = PORT_EAST;
    else
      route = PORT_LOCAL;
  end

  // an arbiter may only pick this input while it has a head flit.
  a_grant_needs_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    grant |-> req_valid
  ) else $error("input_port granted without a request");

  // a waiting head keeps its word and its route until it is granted.
  a_head_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    req_valid && !grant |=> req_valid && $stable(head_flit.raw) && $stable(req_port)
  ) else $error("input_port head changed before grant");

endmodule

// ==== rtl/output_arbiter.sv ====
// round-robin arbiter and output register for one router output port
`timescale 1ns/1ns
`include "noc_defines.svh"

module output_arbiter
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`NOC_PORTS-1:0] req,
  input  noc_pkg::flit_u        req_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] grant,
  output logic                  out_valid,
  input  logic                  out_ready,
  output noc_pkg::flit_u        out_flit
);
  import noc_pkg::*;

  typedef enum logic {
    ST_EMPTY,
    ST_HOLD
  } state_e;

  state_e    state;
  state_e    state_nxt;
  port_idx_t ptr;
  port_idx_t win_idx;
  logic      win_found;
  logic      can_load;
  logic      load;
  flit_u     flit_q;

  // the register can take a new flit when it is empty or drains this cycle.
  assign can_load  = (state == ST_EMPTY) || out_ready;
  assign load      = win_found && can_load;
  assign out_valid = (state == ST_HOLD);
  assign out_flit  = flit_q;

  // search the requests starting at the pointer, wrapping after west.
  always_comb
  begin : search
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = ptr;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      cand = int'(ptr) + i;
      if (cand >= `NOC_PORTS)
        cand = cand - `NOC_PORTS;
      if (!win_found && req[cand])
      begin
        win_found = 1'b1;
        win_idx   = port_idx_t'(cand);
      end
    end
  end

  always_comb
  begin
    grant = '0;
    if (load)
      grant[win_idx] = 1'b1;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_EMPTY: if (load) state_nxt = ST_HOLD;
      ST_HOLD:  if (out_ready && !load) state_nxt = ST_EMPTY;
      default:  state_nxt = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ST_EMPTY;
      ptr   <= port_idx_t'(PORT_LOCAL);
    end
    else
    begin
      state <= state_nxt;
      // the winner goes to the back of the line.
      if (load)
        ptr <= (win_idx == port_idx_t'(`NOC_PORTS - 1)) ? '0 : win_idx + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      flit_q <= req_flit[win_idx];
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(grant)
  ) else $error("output_arbiter grant not one-hot");

  a_grant_to_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    (grant & ~req) == '0
  ) else $error("output_arbiter granted a non-requester");

  // a stalled output keeps its flit until the downstream side takes it.
  a_out_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flit.raw)
  ) else $error("output_arbiter flit changed under back-pressure");

endmodule

// ==== rtl/mesh_router.sv ====
// five-port mesh router tile with request fan-out and grant gathering
`timescale 1ns/1ns
`include "noc_defines.svh"

module mesh_router
#(
  parameter int unsigned ROUTER_ROW = 0,
  parameter int unsigned ROUTER_COL = 0
)
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`NOC_PORTS-1:0] in_valid,
  input  noc_pkg::flit_u        in_flit [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] in_ready,
  output logic [`NOC_PORTS-1:0] out_valid,
  input  logic [`NOC_PORTS-1:0] out_ready,
  output noc_pkg::flit_u        out_flit [`NOC_PORTS]
);
  import noc_pkg::*;

  logic [`NOC_PORTS-1:0] req_valid;
  port_idx_t             req_port  [`NOC_PORTS];
  flit_u                 head_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] in_grant;

  // arb_req and arb_grant are indexed by output, grant_to_in by input.
  logic [`NOC_PORTS-1:0] arb_req     [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] arb_grant   [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] grant_to_in [`NOC_PORTS];

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : g_port
    input_port
    #(
      .ROUTER_ROW (ROUTER_ROW),
      .ROUTER_COL (ROUTER_COL)
    )
    u_in
    (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid[p]),
      .in_flit   (in_flit[p]),
      .in_ready  (in_ready[p]),
      .grant     (in_grant[p]),
      .req_valid (req_valid[p]),
      .req_port  (req_port[p]),
      .head_flit (head_flit[p])
    );

    output_arbiter u_arb
    (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (arb_req[p]),
      .req_flit  (head_flit),
      .grant     (arb_grant[p]),
      .out_valid (out_valid[p]),
      .out_ready (out_ready[p]),
      .out_flit  (out_flit[p])
    );

    // each head asks for one output, so at most one arbiter may pick it.
    a_single_grant: assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0(grant_to_in[p])
    ) else $error("input %0d granted by more than one output", p);
  end

  always_comb
  begin
    for (int o = 0; o < `NOC_PORTS; o++)
    begin
      for (int i = 0; i < `NOC_PORTS; i++)
      begin
        arb_req[o][i]     = req_valid[i] && (req_port[i] == port_idx_t'(o));
        grant_to_in[i][o] = arb_grant[o][i];
      end
    end
    for (int i = 0; i < `NOC_PORTS; i++)
      in_grant[i] = |grant_to_in[i];
  end

endmodule

// ==== tests/router_checker.sv ====
// reference route model, per-output scoreboards, stall and fairness checks, test report
`timescale 1ns/1ns
`include "noc_defines.svh"

module router_checker
#(
  parameter int unsigned ROUTER_ROW = 0,
  parameter int unsigned ROUTER_COL = 0
)
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`NOC_PORTS-1:0] in_valid,
  input  noc_pkg::flit_u        in_flit [`NOC_PORTS],
  input  logic [`NOC_PORTS-1:0] in_ready,
  input  logic [`NOC_PORTS-1:0] out_valid,
  input  logic [`NOC_PORTS-1:0] out_ready,
  input  noc_pkg::flit_u        out_flit [`NOC_PORTS],
  input  logic                  fair_mode,
  input  logic                  test_end,
  input  int                    test_id,
  input  logic                  report_end,
  output int                    pending,
  output int                    errors
);
  import noc_pkg::*;

  // one queue per output and source input, at index output * 5 + input.
  // only flits of the same input keep their order at an output.
  logic [`NOC_FLIT_W-1:0] model_q [`NOC_PORTS * `NOC_PORTS][$];
  logic [`NOC_FLIT_W-1:0] held [`NOC_PORTS];
  logic [`NOC_PORTS-1:0]  stalled = '0;
  int accepted  [`NOC_PORTS] = '{default: 0};
  int delivered [`NOC_PORTS] = '{default: 0};
  int last_pos  [`NOC_PORTS] = '{default: -1};
  int local_pos = 0;
  int n_in = 0;
  int n_out = 0;
  int err_count = 0;
  int tests = 0;
  int test_in = 0;
  int test_out = 0;
  int test_err = 0;

  assign pending = n_in - n_out;
  assign errors  = err_count;

  // row first, then column; the arrival port does not matter.
  function automatic int predict_port(flit_u f);
    if (f.hdr.dst_row < ROUTER_ROW)
      return int'(PORT_NORTH);
    if (f.hdr.dst_row > ROUTER_ROW)
      return int'(PORT_SOUTH);
    if (f.hdr.dst_col < ROUTER_COL)
      return int'(PORT_WEST);
    if (f.hdr.dst_col > ROUTER_COL)
      return int'(PORT_EAST);
    return int'(PORT_LOCAL);
  endfunction

  function automatic string phase_name(int id);
    case (id)
      1:       return "routing and order, free flow";
      2:       return "random back-pressure";
      3:       return "local output fairness";
      default: return "unnamed";
    endcase
  endfunction

  task automatic value_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic fault(input string msg);
    $display("%s", msg);
    err_count++;
  endtask

  task automatic check_output(input int o);
    logic [`NOC_FLIT_W-1:0] exp_raw;
    int src;
    int slot;
    src  = int'(out_flit[o].hdr.tag);
    slot = o * `NOC_PORTS + src;
    n_out++;
    if (src < `NOC_PORTS)
      delivered[src]++;
    if (src >= `NOC_PORTS)
      value_error($sformatf("output %0d sent %h with an unknown source tag",
                            o, out_flit[o].raw));
    else if (model_q[slot].size() == 0)
      value_error($sformatf("output %0d sent %h when no flit from input %0d was due",
                            o, out_flit[o].raw, src));
    else
    begin
      exp_raw = model_q[slot].pop_front();
      if (exp_raw != out_flit[o].raw)
        value_error($sformatf("output %0d sent %h, expected %h", o, out_flit[o].raw, exp_raw));
    end
    // with every input busy, one input waits behind at most four others.
    if (fair_mode && o == int'(PORT_LOCAL) && src < `NOC_PORTS)
    begin
      if (last_pos[src] >= 0 && local_pos - last_pos[src] - 1 > `NOC_PORTS - 1)
        fault($sformatf("input %0d waited behind %0d other flits at the local output",
                        src, local_pos - last_pos[src] - 1));
      last_pos[src] = local_pos;
      local_pos++;
    end
  endtask

  task automatic finish_test();
    int left;
    left = 0;
    for (int q = 0; q < `NOC_PORTS * `NOC_PORTS; q++)
      left += model_q[q].size();
    if (left != 0)
      fault($sformatf("test %0d ended with %0d flits never delivered", test_id, left));
    if (n_in - test_in != n_out - test_out)
      fault($sformatf("test %0d accepted %0d flits but delivered %0d",
                      test_id, n_in - test_in, n_out - test_out));
    $display("test %0d (%s): %0d flits in, %0d out, %0d errors", test_id, phase_name(test_id),
             n_in - test_in, n_out - test_out, err_count - test_err);
    tests++;
    test_in  = n_in;
    test_out = n_out;
    test_err = err_count;
  endtask

  always @(posedge clk)
  begin
    if (!fair_mode)
    begin
      local_pos = 0;
      for (int p = 0; p < `NOC_PORTS; p++)
        last_pos[p] = -1;
    end
    if (arst_n)
    begin
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        // a full queue means at least four flits are still inside the router.
        if (!in_ready[p] && accepted[p] - delivered[p] < `NOC_FIFO_DEPTH)
          fault($sformatf("input %0d refused a flit with only %0d flits inside the router",
                          p, accepted[p] - delivered[p]));
        if (stalled[p] && (!out_valid[p] || out_flit[p].raw != held[p]))
          value_error($sformatf("output %0d changed from %h to %h under back-pressure",
                                p, held[p], out_flit[p].raw));
        stalled[p] = out_valid[p] && !out_ready[p];
        held[p]    = out_flit[p].raw;
      end
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (in_valid[p] && in_ready[p])
        begin
          model_q[predict_port(in_flit[p]) * `NOC_PORTS + p].push_back(in_flit[p].raw);
          accepted[p]++;
          n_in++;
        end
      end
      for (int o = 0; o < `NOC_PORTS; o++)
      begin
        if (out_valid[o] && out_ready[o])
          check_output(o);
      end
      if (test_end)
        finish_test();
      if (report_end)
        $display("%0d tests, %0d flits checked, %0d errors", tests, n_out, err_count);
    end
  end

endmodule

// ==== tests/tb_router.sv ====
// testbench top with clock, reset, random traffic phases and watchdog for the router tile
`timescale 1ns/1ns
`include "noc_defines.svh"

module tb_router;
  import noc_pkg::*;

  localparam int unsigned ROW = 1;
  localparam int unsigned COL = 2;
  localparam int RESET_CYCLES = 16;
  localparam int FREE_FLITS   = 60;
  localparam int STALL_FLITS  = 60;
  localparam int FAIR_FLITS   = 40;
  localparam int WATCHDOG_CYCLES =
    `NOC_PORTS * (FREE_FLITS + STALL_FLITS + FAIR_FLITS) * 40 + RESET_CYCLES;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic [`NOC_PORTS-1:0]     in_valid;
  flit_u                     in_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0]     in_ready;
  logic [`NOC_PORTS-1:0]     out_valid;
  logic [`NOC_PORTS-1:0]     out_ready;
  flit_u                     out_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0]     took = '0;
  logic                      fair_mode;
  logic                      test_end;
  logic                      report_end;
  int                        test_id;
  int                        pending;
  int                        errors;
  logic [31:0]               lcg_state;
  logic [`NOC_PAYLOAD_W-1:0] seq [`NOC_PORTS];

  always #4 clk = ~clk;

  mesh_router
  #(
    .ROUTER_ROW (ROW),
    .ROUTER_COL (COL)
  )
  DUT
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

  router_checker
  #(
    .ROUTER_ROW (ROW),
    .ROUTER_COL (COL)
  )
  u_checker
  (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_flit    (in_flit),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_flit   (out_flit),
    .fair_mode  (fair_mode),
    .test_end   (test_end),
    .test_id    (test_id),
    .report_end (report_end),
    .pending    (pending),
    .errors     (errors)
  );

  // remembers which inputs completed a transfer at the last rising edge.
  always @(posedge clk)
    took <= in_valid & in_ready;

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // mode 0 is free flow, mode 1 adds random out_ready, mode 2 sends every flit to local.
  task automatic run_phase(input int id, input int n, input int mode);
    int          sent [`NOC_PORTS];
    logic        busy;
    logic [15:0] r;
    flit_u       f;
    for (int p = 0; p < `NOC_PORTS; p++)
      sent[p] = 0;
    test_id   = id;
    fair_mode = (mode == 2);
    busy      = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        if (took[p])
          in_valid[p] = 1'b0;
        r = lcg_next();
        if (!in_valid[p] && sent[p] < n && (mode == 2 || r[15:14] != 2'b00))
        begin
          f.hdr.tag     = 4'(p);
          f.hdr.dst_row = (mode == 2) ? 2'(ROW) : r[13:12];
          f.hdr.dst_col = (mode == 2) ? 2'(COL) : r[11:10];
          f.hdr.payload = seq[p];
          in_flit[p]    = f;
          in_valid[p]   = 1'b1;
          seq[p]        = seq[p] + 1'b1;
          sent[p]++;
        end
        if (in_valid[p] || sent[p] < n)
          busy = 1'b1;
      end
      r = lcg_next();
      out_ready = (mode == 1) ? r[15:11] : '1;
    end
    // drain with the outputs open, then a few idle cycles to catch late duplicates.
    out_ready = '1;
    while (pending != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    fair_mode = 1'b0;
    test_end  = 1'b1;
    @(negedge clk);
    test_end  = 1'b0;
  endtask

  initial
  begin
    arst_n     = 1'b0;
    in_valid   = '0;
    out_ready  = '1;
    fair_mode  = 1'b0;
    test_end   = 1'b0;
    report_end = 1'b0;
    test_id    = 0;
    lcg_state  = 32'd10;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      in_flit[p] = '0;
      seq[p]     = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    run_phase(1, FREE_FLITS, 0);
    run_phase(2, STALL_FLITS, 1);
    run_phase(3, FAIR_FLITS, 2);
    report_end = 1'b1;
    @(negedge clk);
    report_end = 1'b0;
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/noc_pkg.sv
rtl/flit_fifo.sv
rtl/input_port.sv
rtl/output_arbiter.sv
rtl/mesh_router.sv
tests/router_checker.sv
tests/tb_router.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_router
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and search for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
